//--- rv_ctrl.f
+incdir+.
rv_ctrl_pkg.sv
rv_op_decode.sv
rv_x_ctrl.sv
rv_w_ctrl.sv
rv_ctrl_top.sv
tb_rv_ctrl.sv

//--- Bender.yml
package:
  name: rv_ctrl

sources:
  - rv_ctrl_pkg.sv
  - rv_op_decode.sv
  - rv_x_ctrl.sv
  - rv_w_ctrl.sv
  - rv_ctrl_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_ctrl.sv

//--- tb_rv_ctrl_ref.svh
// Reference model for the control path testbench
// Expected execute and writeback bundles computed straight from the
// instruction bits, following the RV32I opcode and funct fields

`ifndef TB_RV_CTRL_REF_SVH
`define TB_RV_CTRL_REF_SVH

// ALU table shared by OP and OP_IMM
function automatic rv_ctrl_pkg::alu_op_e ref_alu_op(input logic       reg_form,
                                                    input logic [2:0] f3,
                                                    input logic       alt);
  case (f3)
    3'b000: begin
      if (reg_form && alt) begin
        return rv_ctrl_pkg::ALU_SUB;
      end
      return rv_ctrl_pkg::ALU_ADD; // ADDI ignores funct7
    end
    3'b001: return rv_ctrl_pkg::ALU_SLL;
    3'b010: return rv_ctrl_pkg::ALU_SLT;
    3'b011: return rv_ctrl_pkg::ALU_SLTU;
    3'b100: return rv_ctrl_pkg::ALU_XOR;
    3'b101: begin
      if (alt) begin
        return rv_ctrl_pkg::ALU_SRA;
      end
      return rv_ctrl_pkg::ALU_SRL;
    end
    3'b110: return rv_ctrl_pkg::ALU_OR;
    default: return rv_ctrl_pkg::ALU_AND;
  endcase
endfunction

function automatic rv_ctrl_pkg::x_ctrl_t ref_x_ctrl(input logic [31:0] ins);
  rv_ctrl_pkg::x_ctrl_t x;
  logic                 alt;
  alt       = (ins[31:25] == 7'b0100000);
  x.alu_op  = rv_ctrl_pkg::ALU_ADD;
  x.a_sel   = rv_ctrl_pkg::A_RS1;
  x.b_imm   = 1'b1;
  x.imm_sel = rv_ctrl_pkg::FMT_I;
  x.br_un   = 1'b0;
  x.illegal = 1'b0;
  case (ins[6:0])
    7'b0110011: begin // OP
      x.alu_op = ref_alu_op(1'b1, ins[14:12], alt);
      x.b_imm  = 1'b0;
    end
    7'b0010011: x.alu_op = ref_alu_op(1'b0, ins[14:12], alt); // OP_IMM
    7'b0000011, 7'b1100111: x.imm_sel = rv_ctrl_pkg::FMT_I; // LOAD, JALR
    7'b0100011: x.imm_sel = rv_ctrl_pkg::FMT_S; // STORE
    7'b1100011: begin // BRANCH
      x.a_sel   = rv_ctrl_pkg::A_PC;
      x.imm_sel = rv_ctrl_pkg::FMT_B;
      x.br_un   = (ins[14:12] == 3'b110) || (ins[14:12] == 3'b111);
    end
    7'b0110111: begin // LUI
      x.a_sel   = rv_ctrl_pkg::A_ZERO;
      x.imm_sel = rv_ctrl_pkg::FMT_U;
    end
    7'b0010111: begin // AUIPC
      x.a_sel   = rv_ctrl_pkg::A_PC;
      x.imm_sel = rv_ctrl_pkg::FMT_U;
    end
    7'b1101111: begin // JAL
      x.a_sel   = rv_ctrl_pkg::A_PC;
      x.imm_sel = rv_ctrl_pkg::FMT_J;
    end
    default: begin
      x.illegal = 1'b1;
      x.b_imm   = 1'b0;
    end
  endcase
  return x;
endfunction

function automatic rv_ctrl_pkg::w_ctrl_t ref_w_ctrl(input logic [31:0] ins);
  rv_ctrl_pkg::w_ctrl_t w;
  w.rf_we  = 1'b1;
  w.wb_sel = rv_ctrl_pkg::WB_ALU;
  w.pc_sel = rv_ctrl_pkg::PC_PLUS4;
  case (ins[6:0])
    7'b0000011: w.wb_sel = rv_ctrl_pkg::WB_MEM; // LOAD
    7'b1100111, 7'b1101111: begin // JALR, JAL
      w.wb_sel = rv_ctrl_pkg::WB_PC4;
      w.pc_sel = rv_ctrl_pkg::PC_ALU;
    end
    7'b0110011, 7'b0010011, 7'b0110111, 7'b0010111: w.rf_we = 1'b1;
    default: w.rf_we = 1'b0; // Store, branch, unknown
  endcase
  return w;
endfunction

`endif

//--- tb_rv_ctrl.sv
// Testbench for the RV32I control path
// Clock, reset, directed and random instruction stimulus
// Expected-value queues with latency check, compare task and summary

`timescale 1ns/1ps

module tb_rv_ctrl;

  typedef struct packed {
    logic [31:0]          stamp; // Cycle in which the strobe was presented
    rv_ctrl_pkg::x_ctrl_t x;
    rv_ctrl_pkg::w_ctrl_t w;
  } exp_t;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 instr_valid;
  logic [31:0]          instr;
  logic                 x_valid;
  rv_ctrl_pkg::x_ctrl_t x_ctrl;
  logic                 w_valid;
  rv_ctrl_pkg::w_ctrl_t w_ctrl;

  logic [31:0] cyc = 32'd0;
  logic        checking = 1'b0;
  int          errors = 0;
  int          timeouts = 0;
  exp_t        x_q[$];
  exp_t        w_q[$];
  exp_t        x_e;
  exp_t        w_e;

  `include "tb_rv_ctrl_ref.svh"

  rv_ctrl_top i_rv_ctrl_top (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .x_valid     (x_valid),
    .x_ctrl      (x_ctrl),
    .w_valid     (w_valid),
    .w_ctrl      (w_ctrl)
  );

  always #10 clk = ~clk; // 20 ns period

  always @(posedge clk) begin
    cyc <= cyc + 32'd1;
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("** Error: %s expected 0x%0h actual 0x%0h at cycle %0d", name, exp, act, cyc);
    end
  endtask

  function automatic logic [31:0] enc(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
  endfunction

  function automatic logic [31:0] rand_instr();
    logic [31:0] w;
    logic [3:0]  pick;
    w    = $urandom;
    pick = $urandom_range(0, 9);
    case (pick)
      4'd0: w[6:0] = rv_ctrl_pkg::OPC_OP;
      4'd1: w[6:0] = rv_ctrl_pkg::OPC_OP_IMM;
      4'd2: w[6:0] = rv_ctrl_pkg::OPC_LOAD;
      4'd3: w[6:0] = rv_ctrl_pkg::OPC_JALR;
      4'd4: w[6:0] = rv_ctrl_pkg::OPC_STORE;
      4'd5: w[6:0] = rv_ctrl_pkg::OPC_BRANCH;
      4'd6: w[6:0] = rv_ctrl_pkg::OPC_LUI;
      4'd7: w[6:0] = rv_ctrl_pkg::OPC_AUIPC;
      4'd8: w[6:0] = rv_ctrl_pkg::OPC_JAL;
      default: w[6:0] = w[6:0]; // Mostly unknown opcodes
    endcase
    if ($urandom_range(0, 3) == 0) begin
      w[31:25] = 7'b0100000; // Alternate funct7
    end
    return w;
  endfunction

  task automatic drive_instr(input logic v, input logic [31:0] w);
    exp_t e;
    @(negedge clk);
    instr_valid = v;
    instr       = w;
    if (v) begin
      e.stamp = cyc;
      e.x     = ref_x_ctrl(w);
      e.w     = ref_w_ctrl(w);
      x_q.push_back(e);
      w_q.push_back(e);
    end
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while ((x_q.size() != 0 || w_q.size() != 0) && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (x_q.size() != 0 || w_q.size() != 0) begin
      timeouts++;
      $display("Timeout: outputs for %0d instructions never arrived", x_q.size() + w_q.size());
    end
  endtask

  // Outputs settle after the rising edge, so compare on the falling edge
  always @(negedge clk) begin
    if (checking) begin
      if (x_valid) begin
        if (x_q.size() == 0) begin
          errors++;
          $display("x_valid went high at cycle %0d with no instruction pending", cyc);
        end else begin
          x_e = x_q.pop_front();
          check_val("x_delay", 32'd1, cyc - x_e.stamp);
          check_val("x_ctrl.alu_op", x_e.x.alu_op, x_ctrl.alu_op);
          check_val("x_ctrl.a_sel", x_e.x.a_sel, x_ctrl.a_sel);
          check_val("x_ctrl.b_imm", x_e.x.b_imm, x_ctrl.b_imm);
          check_val("x_ctrl.imm_sel", x_e.x.imm_sel, x_ctrl.imm_sel);
          check_val("x_ctrl.br_un", x_e.x.br_un, x_ctrl.br_un);
          check_val("x_ctrl.illegal", x_e.x.illegal, x_ctrl.illegal);
        end
      end else if (x_q.size() != 0 && x_q[0].stamp + 32'd1 <= cyc) begin
        errors++;
        $display("x_valid stayed low at cycle %0d for an instruction from cycle %0d",
                 cyc, x_q[0].stamp);
        void'(x_q.pop_front());
      end
      if (w_valid) begin
        if (w_q.size() == 0) begin
          errors++;
          $display("w_valid went high at cycle %0d with no instruction pending", cyc);
        end else begin
          w_e = w_q.pop_front();
          check_val("w_delay", 32'd2, cyc - w_e.stamp);
          check_val("w_ctrl.rf_we", w_e.w.rf_we, w_ctrl.rf_we);
          check_val("w_ctrl.wb_sel", w_e.w.wb_sel, w_ctrl.wb_sel);
          check_val("w_ctrl.pc_sel", w_e.w.pc_sel, w_ctrl.pc_sel);
        end
      end else begin
        check_val("w_ctrl.rf_we", 32'd0, w_ctrl.rf_we); // Bubble never writes
        if (w_q.size() != 0 && w_q[0].stamp + 32'd2 <= cyc) begin
          errors++;
          $display("w_valid stayed low at cycle %0d for an instruction from cycle %0d",
                   cyc, w_q[0].stamp);
          void'(w_q.pop_front());
        end
      end
    end
  end

  initial begin
    int i;
    int f3;
    void'($urandom(71));
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = 32'd0;
    repeat (16) @(negedge clk);
    rst      = 1'b0;
    checking = 1'b1;

    // Idle after reset, random words without a strobe
    for (i = 0; i < 6; i++) begin
      drive_instr(1'b0, $urandom);
      check_val("x_valid", 32'd0, x_valid);
      check_val("w_valid", 32'd0, w_valid);
      check_val("w_ctrl.rf_we", 32'd0, w_ctrl.rf_we);
    end

    // R-type and I-type ALU sweep, back to back
    for (f3 = 0; f3 < 8; f3++) begin
      drive_instr(1'b1, enc(7'b0000000, f3[2:0], rv_ctrl_pkg::OPC_OP));
    end
    drive_instr(1'b1, enc(7'b0100000, 3'b000, rv_ctrl_pkg::OPC_OP)); // SUB
    drive_instr(1'b1, enc(7'b0100000, 3'b101, rv_ctrl_pkg::OPC_OP)); // SRA
    for (f3 = 0; f3 < 8; f3++) begin
      drive_instr(1'b1, enc(7'b0000000, f3[2:0], rv_ctrl_pkg::OPC_OP_IMM));
    end
    drive_instr(1'b1, enc(7'b0100000, 3'b101, rv_ctrl_pkg::OPC_OP_IMM)); // SRAI
    drive_instr(1'b1, enc(7'b0100000, 3'b000, rv_ctrl_pkg::OPC_OP_IMM)); // Still ADDI

    // Branches, 010 and 011 are not defined
    for (f3 = 0; f3 < 8; f3++) begin
      if (f3 != 2 && f3 != 3) begin
        drive_instr(1'b1, enc(7'b0000000, f3[2:0], rv_ctrl_pkg::OPC_BRANCH));
      end
    end

    drive_instr(1'b1, enc(7'b0000000, 3'b010, rv_ctrl_pkg::OPC_LOAD));
    drive_instr(1'b1, enc(7'b0000000, 3'b010, rv_ctrl_pkg::OPC_STORE));
    drive_instr(1'b1, enc(7'b0100000, 3'b000, rv_ctrl_pkg::OPC_LUI));
    drive_instr(1'b1, enc(7'b0000000, 3'b111, rv_ctrl_pkg::OPC_AUIPC));
    drive_instr(1'b1, enc(7'b0000000, 3'b000, rv_ctrl_pkg::OPC_JAL));
    drive_instr(1'b1, enc(7'b0000000, 3'b000, rv_ctrl_pkg::OPC_JALR));
    drive_instr(1'b1, enc(7'b0000000, 3'b000, 7'b1111111)); // Unknown opcode
    drive_instr(1'b1, enc(7'b0000000, 3'b000, 7'b0001111)); // FENCE, not handled
    drive_instr(1'b0, 32'd0);
    wait_drain(20);

    // Random stream with a random strobe
    for (i = 0; i < 300; i++) begin
      drive_instr($urandom_range(0, 3) != 0, rand_instr());
    end
    drive_instr(1'b0, 32'd0);
    wait_drain(20);
    repeat (3) @(negedge clk);

    $display("Summary: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- rv_ctrl_top.sv
// Control path top level
// Opcode decode into the X stage register, then the W stage register
// Execute control from the X stage, writeback control from the W stage
// Write enable gated by the W stage valid bit

`timescale 1ns/1ps

module rv_ctrl_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            instr_valid,
  input  logic [rv_ctrl_pkg::INSTR_W-1:0] instr,
  output logic                            x_valid,
  output rv_ctrl_pkg::x_ctrl_t            x_ctrl,
  output logic                            w_valid,
  output rv_ctrl_pkg::w_ctrl_t            w_ctrl
);

  rv_ctrl_pkg::dec_t    d_dec;   // Decode of the incoming word
  rv_ctrl_pkg::dec_t    x_dec_q; // X stage record
  rv_ctrl_pkg::dec_t    w_dec_q; // W stage record
  logic                 x_valid_q;
  logic                 w_valid_q;
  rv_ctrl_pkg::w_ctrl_t w_ctrl_raw;

  rv_op_decode i_rv_op_decode (
    .instr (instr),
    .dec   (d_dec)
  );

  // Valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      x_valid_q <= 1'b0;
      w_valid_q <= 1'b0;
    end else begin
      x_valid_q <= instr_valid;
      w_valid_q <= x_valid_q;
    end
  end

  // Records follow the strobes, bubbles leave them stale
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      x_dec_q <= d_dec;
    end
    if (x_valid_q) begin
      w_dec_q <= x_dec_q;
    end
  end

  rv_x_ctrl i_rv_x_ctrl (
    .dec    (x_dec_q),
    .x_ctrl (x_ctrl)
  );

  rv_w_ctrl i_rv_w_ctrl (
    .dec    (w_dec_q),
    .w_ctrl (w_ctrl_raw)
  );

  assign x_valid = x_valid_q;
  assign w_valid = w_valid_q;

  always_comb begin
    w_ctrl       = w_ctrl_raw;
    w_ctrl.rf_we = w_ctrl_raw.rf_we & w_valid_q; // No write on a bubble
  end

endmodule

//--- rv_w_ctrl.sv
// Writeback-stage control
// Register-file write enable, writeback source and next-PC source

`timescale 1ns/1ps

module rv_w_ctrl (
  input  rv_ctrl_pkg::dec_t    dec,
  output rv_ctrl_pkg::w_ctrl_t w_ctrl
);

  logic is_jump; // JAL or JALR

  assign is_jump = (dec.op == rv_ctrl_pkg::CLS_JAL) ||
                   (dec.op == rv_ctrl_pkg::CLS_JALR);

  always_comb begin
    case (dec.op)
      rv_ctrl_pkg::CLS_OP,
      rv_ctrl_pkg::CLS_OP_IMM,
      rv_ctrl_pkg::CLS_LOAD,
      rv_ctrl_pkg::CLS_JALR,
      rv_ctrl_pkg::CLS_LUI,
      rv_ctrl_pkg::CLS_AUIPC,
      rv_ctrl_pkg::CLS_JAL: w_ctrl.rf_we = 1'b1;
      default:              w_ctrl.rf_we = 1'b0; // Store, branch, illegal
    endcase

    if (dec.op == rv_ctrl_pkg::CLS_LOAD) begin
      w_ctrl.wb_sel = rv_ctrl_pkg::WB_MEM;
    end else if (is_jump) begin
      w_ctrl.wb_sel = rv_ctrl_pkg::WB_PC4; // Link address
    end else begin
      w_ctrl.wb_sel = rv_ctrl_pkg::WB_ALU;
    end

    // Branches always fall through, no resolution here
    if (is_jump) begin
      w_ctrl.pc_sel = rv_ctrl_pkg::PC_ALU;
    end else begin
      w_ctrl.pc_sel = rv_ctrl_pkg::PC_PLUS4;
    end
  end

endmodule

//--- rv_x_ctrl.sv
// Execute-stage control
// ALU operation from class, funct3 and the alternate bit,
// operand selects, immediate format and unsigned-branch flag

`timescale 1ns/1ps

module rv_x_ctrl (
  input  rv_ctrl_pkg::dec_t    dec,
  output rv_ctrl_pkg::x_ctrl_t x_ctrl
);

  logic                  is_reg_alu; // Register or immediate ALU class
  rv_ctrl_pkg::alu_op_e  alu_op;

  assign is_reg_alu = (dec.op == rv_ctrl_pkg::CLS_OP) ||
                      (dec.op == rv_ctrl_pkg::CLS_OP_IMM);

  always_comb begin
    alu_op = rv_ctrl_pkg::ALU_ADD; // Address and link arithmetic
    if (is_reg_alu) begin
      case (dec.funct3)
        3'b000: begin
          // ADDI has no subtract form
          if (dec.alt && dec.op == rv_ctrl_pkg::CLS_OP) begin
            alu_op = rv_ctrl_pkg::ALU_SUB;
          end else begin
            alu_op = rv_ctrl_pkg::ALU_ADD;
          end
        end
        3'b001: alu_op = rv_ctrl_pkg::ALU_SLL;
        3'b010: alu_op = rv_ctrl_pkg::ALU_SLT;
        3'b011: alu_op = rv_ctrl_pkg::ALU_SLTU;
        3'b100: alu_op = rv_ctrl_pkg::ALU_XOR;
        3'b101: begin
          if (dec.alt) begin
            alu_op = rv_ctrl_pkg::ALU_SRA;
          end else begin
            alu_op = rv_ctrl_pkg::ALU_SRL;
          end
        end
        3'b110: alu_op = rv_ctrl_pkg::ALU_OR;
        default: alu_op = rv_ctrl_pkg::ALU_AND; // 111
      endcase
    end
  end

  always_comb begin
    x_ctrl.alu_op = alu_op;

    case (dec.op)
      rv_ctrl_pkg::CLS_BRANCH,
      rv_ctrl_pkg::CLS_JAL,
      rv_ctrl_pkg::CLS_AUIPC: x_ctrl.a_sel = rv_ctrl_pkg::A_PC;
      rv_ctrl_pkg::CLS_LUI:   x_ctrl.a_sel = rv_ctrl_pkg::A_ZERO;
      default:                x_ctrl.a_sel = rv_ctrl_pkg::A_RS1;
    endcase

    x_ctrl.b_imm = (dec.op != rv_ctrl_pkg::CLS_OP) &&
                   (dec.op != rv_ctrl_pkg::CLS_ILLEGAL);

    // R and NONE carry no immediate, default to I
    if (dec.itype == rv_ctrl_pkg::FMT_R || dec.itype == rv_ctrl_pkg::FMT_NONE) begin
      x_ctrl.imm_sel = rv_ctrl_pkg::FMT_I;
    end else begin
      x_ctrl.imm_sel = dec.itype;
    end

    x_ctrl.br_un   = (dec.op == rv_ctrl_pkg::CLS_BRANCH) &&
                     (dec.funct3[2:1] == 2'b11); // BLTU, BGEU
    x_ctrl.illegal = (dec.op == rv_ctrl_pkg::CLS_ILLEGAL);
  end

endmodule

//--- rv_op_decode.sv
// Opcode decoder
// Sorts an instruction word into operation class and format,
// and extracts funct3 and the funct7 alternate bit

`timescale 1ns/1ps

module rv_op_decode (
  input  logic [rv_ctrl_pkg::INSTR_W-1:0] instr,
  output rv_ctrl_pkg::dec_t               dec
);

  rv_ctrl_pkg::op_class_e op;
  rv_ctrl_pkg::itype_e    itype;

  always_comb begin
    case (instr[6:0])
      rv_ctrl_pkg::OPC_OP:     op = rv_ctrl_pkg::CLS_OP;
      rv_ctrl_pkg::OPC_OP_IMM: op = rv_ctrl_pkg::CLS_OP_IMM;
      rv_ctrl_pkg::OPC_LOAD:   op = rv_ctrl_pkg::CLS_LOAD;
      rv_ctrl_pkg::OPC_JALR:   op = rv_ctrl_pkg::CLS_JALR;
      rv_ctrl_pkg::OPC_STORE:  op = rv_ctrl_pkg::CLS_STORE;
      rv_ctrl_pkg::OPC_BRANCH: op = rv_ctrl_pkg::CLS_BRANCH;
      rv_ctrl_pkg::OPC_LUI:    op = rv_ctrl_pkg::CLS_LUI;
      rv_ctrl_pkg::OPC_AUIPC:  op = rv_ctrl_pkg::CLS_AUIPC;
      rv_ctrl_pkg::OPC_JAL:    op = rv_ctrl_pkg::CLS_JAL;
      default:                 op = rv_ctrl_pkg::CLS_ILLEGAL; // Unknown opcode
    endcase
  end

  always_comb begin
    case (op)
      rv_ctrl_pkg::CLS_OP:     itype = rv_ctrl_pkg::FMT_R;
      rv_ctrl_pkg::CLS_OP_IMM,
      rv_ctrl_pkg::CLS_LOAD,
      rv_ctrl_pkg::CLS_JALR:   itype = rv_ctrl_pkg::FMT_I;
      rv_ctrl_pkg::CLS_STORE:  itype = rv_ctrl_pkg::FMT_S;
      rv_ctrl_pkg::CLS_BRANCH: itype = rv_ctrl_pkg::FMT_B;
      rv_ctrl_pkg::CLS_LUI,
      rv_ctrl_pkg::CLS_AUIPC:  itype = rv_ctrl_pkg::FMT_U;
      rv_ctrl_pkg::CLS_JAL:    itype = rv_ctrl_pkg::FMT_J;
      default:                 itype = rv_ctrl_pkg::FMT_NONE;
    endcase
  end

  always_comb begin
    dec.op     = op;
    dec.itype  = itype;
    dec.funct3 = instr[14:12];
    dec.alt    = (instr[31:25] == rv_ctrl_pkg::FUNCT7_ALT); // SUB, SRA, SRAI
  end

endmodule

//--- rv_ctrl_pkg.sv
// Shared types for the RV32I control path
// Operation class, instruction format and ALU operation enums
// Operand, writeback and next-PC select enums
// Decoded record and per-stage control bundles
// Major opcode and funct7 constants

package rv_ctrl_pkg;

  localparam int INSTR_W = 32; // One instruction word

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // SUB and SRA/SRAI

  typedef enum logic [3:0] {
    CLS_OP      = 4'd0,
    CLS_OP_IMM  = 4'd1,
    CLS_LOAD    = 4'd2,
    CLS_JALR    = 4'd3,
    CLS_STORE   = 4'd4,
    CLS_BRANCH  = 4'd5,
    CLS_LUI     = 4'd6,
    CLS_AUIPC   = 4'd7,
    CLS_JAL     = 4'd8,
    CLS_ILLEGAL = 4'd9
  } op_class_e;

  typedef enum logic [2:0] {
    FMT_R    = 3'd0,
    FMT_I    = 3'd1,
    FMT_S    = 3'd2,
    FMT_B    = 3'd3,
    FMT_U    = 3'd4,
    FMT_J    = 3'd5,
    FMT_NONE = 3'd6
  } itype_e;

  // Encoding of the ALU select field
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b0001,
    ALU_AND  = 4'b0010,
    ALU_OR   = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SLL  = 4'b0101,
    ALU_SRL  = 4'b0110,
    ALU_SRA  = 4'b0111,
    ALU_SLT  = 4'b1000,
    ALU_SLTU = 4'b1001
  } alu_op_e;

  typedef enum logic [1:0] {
    A_RS1  = 2'd0,
    A_PC   = 2'd1,
    A_ZERO = 2'd2
  } a_sel_e;

  typedef enum logic [1:0] {
    WB_MEM = 2'd0,
    WB_ALU = 2'd1,
    WB_PC4 = 2'd2
  } wb_sel_e;

  typedef enum logic {
    PC_PLUS4 = 1'b0,
    PC_ALU   = 1'b1
  } pc_sel_e;

  typedef struct packed {
    op_class_e  op;
    itype_e     itype;
    logic [2:0] funct3;
    logic       alt;    // funct7 == 0100000
  } dec_t;

  typedef struct packed {
    alu_op_e alu_op;
    a_sel_e  a_sel;
    logic    b_imm;     // Operand B from immediate
    itype_e  imm_sel;
    logic    br_un;     // Unsigned branch compare
    logic    illegal;
  } x_ctrl_t;

  typedef struct packed {
    logic    rf_we;
    wb_sel_e wb_sel;
    pc_sel_e pc_sel;
  } w_ctrl_t;

endpackage
